// File: queue_ctx_pkg.sv
package queue_ctx_pkg;

// host register window on pcie port 0
localparam int PCIE_ADDR_WIDTH = 64;
localparam int HOST_LINE_WIDTH = 512;

// each queue owns one 4 KiB page
localparam int PAGE_LSB = 12;
localparam int QUEUE_IDX_WIDTH = 4;

localparam int REG_WIDTH = 32;
localparam int REG_BYTES = REG_WIDTH / 8;

// word positions of the queue fields inside a host line
localparam int SLOT_COUNT = 4;
localparam int SLOT_TAIL = 0;
localparam int SLOT_HEAD = 1;
localparam int SLOT_ADDR_LO = 2;
localparam int SLOT_ADDR_HI = 3;

typedef logic [QUEUE_IDX_WIDTH-1:0] queue_idx_t;
typedef logic [REG_WIDTH-1:0] ring_ptr_t;
typedef logic [2*REG_WIDTH-1:0] kmem_addr_t;
typedef logic [REG_WIDTH-1:0] reg_word_t;
typedef logic [HOST_LINE_WIDTH-1:0] host_line_t;
typedef logic [HOST_LINE_WIDTH/8-1:0] byte_mask_t;

// one bit per queue field, indexed by slot number
typedef logic [SLOT_COUNT-1:0] slot_strobe_t;

typedef enum logic [1:0] {
    IDLE,
    WAIT_TABLE,
    SWITCH_QUEUE,
    WAIT_DMA
} switch_state_t;

endpackage

// File: queue_table_if.sv
`timescale 1ns/1ps

// one access port of the queue table
interface queue_table_if;

queue_ctx_pkg::queue_idx_t   addr;
logic                        rd_en;
queue_ctx_pkg::slot_strobe_t wr_en;
queue_ctx_pkg::ring_ptr_t    wr_tail;
queue_ctx_pkg::ring_ptr_t    wr_head;
queue_ctx_pkg::reg_word_t    wr_addr_lo;
queue_ctx_pkg::reg_word_t    wr_addr_hi;
queue_ctx_pkg::ring_ptr_t    rd_tail;
queue_ctx_pkg::ring_ptr_t    rd_head;
queue_ctx_pkg::reg_word_t    rd_addr_lo;
queue_ctx_pkg::reg_word_t    rd_addr_hi;

modport user (
    output addr, rd_en, wr_en, wr_tail, wr_head, wr_addr_lo, wr_addr_hi,
    input  rd_tail, rd_head, rd_addr_lo, rd_addr_hi
);

modport tbl (
    input  addr, rd_en, wr_en, wr_tail, wr_head, wr_addr_lo, wr_addr_hi,
    output rd_tail, rd_head, rd_addr_lo, rd_addr_hi
);

modport monitor (
    input addr, rd_en, wr_en, wr_tail, wr_head, wr_addr_lo, wr_addr_hi,
    input rd_tail, rd_head, rd_addr_lo, rd_addr_hi
);

endinterface

// decoded host write, valid for the single cycle after the pcie strobe
interface host_write_if;

queue_ctx_pkg::queue_idx_t                                page;
queue_ctx_pkg::slot_strobe_t                              strobe;
queue_ctx_pkg::reg_word_t [queue_ctx_pkg::SLOT_COUNT-1:0] word;

modport source (output page, strobe, word);
modport sink (input page, strobe, word);

endinterface

// File: queue_table.sv
`timescale 1ns/1ps

module queue_table #(
    parameter int QUEUE_COUNT  = 16,
    parameter int READ_LATENCY = 2
) (
    input logic        pcie_clk,
    queue_table_if.tbl port_a,
    queue_table_if.tbl port_b
);

localparam int PORTS = 2;

queue_ctx_pkg::queue_idx_t   addr [PORTS];
logic                        rd_en [PORTS];
queue_ctx_pkg::slot_strobe_t wr_en [PORTS];
queue_ctx_pkg::reg_word_t    wr_data [PORTS][queue_ctx_pkg::SLOT_COUNT];
queue_ctx_pkg::reg_word_t    rd_data [PORTS][queue_ctx_pkg::SLOT_COUNT];

// address stage, then READ_LATENCY-1 output stages
queue_ctx_pkg::queue_idx_t rd_addr_q [PORTS];
logic [READ_LATENCY-2:0]   rd_en_q [PORTS];

// gather both ports into arrays indexed by port and slot
assign addr[0] = port_a.addr;
assign addr[1] = port_b.addr;
assign rd_en[0] = port_a.rd_en;
assign rd_en[1] = port_b.rd_en;
assign wr_en[0] = port_a.wr_en;
assign wr_en[1] = port_b.wr_en;

assign wr_data[0][queue_ctx_pkg::SLOT_TAIL] = port_a.wr_tail;
assign wr_data[0][queue_ctx_pkg::SLOT_HEAD] = port_a.wr_head;
assign wr_data[0][queue_ctx_pkg::SLOT_ADDR_LO] = port_a.wr_addr_lo;
assign wr_data[0][queue_ctx_pkg::SLOT_ADDR_HI] = port_a.wr_addr_hi;
assign wr_data[1][queue_ctx_pkg::SLOT_TAIL] = port_b.wr_tail;
assign wr_data[1][queue_ctx_pkg::SLOT_HEAD] = port_b.wr_head;
assign wr_data[1][queue_ctx_pkg::SLOT_ADDR_LO] = port_b.wr_addr_lo;
assign wr_data[1][queue_ctx_pkg::SLOT_ADDR_HI] = port_b.wr_addr_hi;

assign port_a.rd_tail = rd_data[0][queue_ctx_pkg::SLOT_TAIL];
assign port_a.rd_head = rd_data[0][queue_ctx_pkg::SLOT_HEAD];
assign port_a.rd_addr_lo = rd_data[0][queue_ctx_pkg::SLOT_ADDR_LO];
assign port_a.rd_addr_hi = rd_data[0][queue_ctx_pkg::SLOT_ADDR_HI];
assign port_b.rd_tail = rd_data[1][queue_ctx_pkg::SLOT_TAIL];
assign port_b.rd_head = rd_data[1][queue_ctx_pkg::SLOT_HEAD];
assign port_b.rd_addr_lo = rd_data[1][queue_ctx_pkg::SLOT_ADDR_LO];
assign port_b.rd_addr_hi = rd_data[1][queue_ctx_pkg::SLOT_ADDR_HI];

always_ff @(posedge pcie_clk) begin
    for (int p = 0; p < PORTS; p++) begin
        if (rd_en[p]) begin
            rd_addr_q[p] <= addr[p];
        end
        rd_en_q[p][0] <= rd_en[p];
        for (int k = 1; k < READ_LATENCY - 1; k++) begin
            rd_en_q[p][k] <= rd_en_q[p][k-1];
        end
    end
end

for (genvar f = 0; f < queue_ctx_pkg::SLOT_COUNT; f++) begin : g_field
    queue_ctx_pkg::reg_word_t mem [QUEUE_COUNT];
    queue_ctx_pkg::reg_word_t stage_q [PORTS][READ_LATENCY-1];

    // stages only load on a read so the output holds between reads
    always_ff @(posedge pcie_clk) begin
        for (int p = 0; p < PORTS; p++) begin
            if (wr_en[p][f]) begin
                mem[addr[p]] <= wr_data[p][f];
            end
            if (rd_en_q[p][0]) begin
                stage_q[p][0] <= mem[rd_addr_q[p]];
            end
            for (int k = 1; k < READ_LATENCY - 1; k++) begin
                if (rd_en_q[p][k]) begin
                    stage_q[p][k] <= stage_q[p][k-1];
                end
            end
        end
    end

    for (genvar p = 0; p < PORTS; p++) begin : g_out
        assign rd_data[p][f] = stage_q[p][READ_LATENCY-2];
    end
end

endmodule

// File: host_reg_port.sv
`timescale 1ns/1ps

module host_reg_port #(
    parameter int READ_LATENCY = 2
) (
    input  logic                                      pcie_clk,
    input  logic                                      pcie_reset_n,
    input  logic [queue_ctx_pkg::PCIE_ADDR_WIDTH-1:0] pcie_address_0,
    input  logic                                      pcie_write_0,
    input  logic                                      pcie_read_0,
    input  queue_ctx_pkg::host_line_t                 pcie_writedata_0,
    input  queue_ctx_pkg::byte_mask_t                 pcie_byteenable_0,
    output queue_ctx_pkg::host_line_t                 pcie_readdata_0,
    output logic                                      pcie_readdatavalid_0,
    queue_table_if.user                               tbl,
    host_write_if.source                              host_wr
);

queue_ctx_pkg::queue_idx_t                                page_idx;
queue_ctx_pkg::slot_strobe_t                              strobe_d;
queue_ctx_pkg::slot_strobe_t                              strobe_q;
queue_ctx_pkg::queue_idx_t                                page_q;
queue_ctx_pkg::reg_word_t [queue_ctx_pkg::SLOT_COUNT-1:0] word_q;
queue_ctx_pkg::queue_idx_t                                rd_page_q;
logic                                                     rd_pending;
logic                                                     rd_issue_q;
logic [READ_LATENCY-1:0]                                  rd_flight;

// every host address is a register page
assign page_idx = pcie_address_0[queue_ctx_pkg::PAGE_LSB +: queue_ctx_pkg::QUEUE_IDX_WIDTH];

// a slot counts as written only when all of its bytes are enabled
always_comb begin
    for (int s = 0; s < queue_ctx_pkg::SLOT_COUNT; s++) begin
        strobe_d[s] = pcie_write_0 &&
            (&pcie_byteenable_0[s*queue_ctx_pkg::REG_BYTES +: queue_ctx_pkg::REG_BYTES]);
    end
end

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        strobe_q <= '0;
    end else begin
        strobe_q <= strobe_d;
    end
end

always_ff @(posedge pcie_clk) begin
    if (pcie_write_0) begin
        page_q <= page_idx;
        word_q <= pcie_writedata_0[queue_ctx_pkg::SLOT_COUNT*queue_ctx_pkg::REG_WIDTH-1:0];
    end
end

assign host_wr.page = page_q;
assign host_wr.strobe = strobe_q;
assign host_wr.word = word_q;

// one read at a time, a host write holds it back
always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        rd_pending <= 1'b0;
        rd_issue_q <= 1'b0;
        rd_flight <= '0;
    end else begin
        rd_issue_q <= 1'b0;
        if (!pcie_write_0 && (rd_pending || pcie_read_0)) begin
            rd_issue_q <= 1'b1;
            rd_pending <= 1'b0;
        end else if (pcie_read_0 && !rd_pending) begin
            rd_pending <= 1'b1;
        end
        rd_flight <= {rd_flight[READ_LATENCY-2:0], rd_issue_q};
    end
end

always_ff @(posedge pcie_clk) begin
    if (pcie_read_0 && !rd_pending) begin
        rd_page_q <= page_idx;
    end
end

// port b carries either the registered write or the read, never both
assign tbl.addr = rd_issue_q ? rd_page_q : page_q;
assign tbl.rd_en = rd_issue_q;
assign tbl.wr_tail = word_q[queue_ctx_pkg::SLOT_TAIL];
assign tbl.wr_head = word_q[queue_ctx_pkg::SLOT_HEAD];
assign tbl.wr_addr_lo = word_q[queue_ctx_pkg::SLOT_ADDR_LO];
assign tbl.wr_addr_hi = word_q[queue_ctx_pkg::SLOT_ADDR_HI];

always_comb begin
    tbl.wr_en = strobe_q;
    // the table tail is owned by the dma side
    tbl.wr_en[queue_ctx_pkg::SLOT_TAIL] = 1'b0;
end

always_comb begin
    pcie_readdata_0 = '0;
    pcie_readdata_0[queue_ctx_pkg::SLOT_TAIL*queue_ctx_pkg::REG_WIDTH +:
        queue_ctx_pkg::REG_WIDTH] = tbl.rd_tail;
    pcie_readdata_0[queue_ctx_pkg::SLOT_HEAD*queue_ctx_pkg::REG_WIDTH +:
        queue_ctx_pkg::REG_WIDTH] = tbl.rd_head;
    pcie_readdata_0[queue_ctx_pkg::SLOT_ADDR_LO*queue_ctx_pkg::REG_WIDTH +:
        queue_ctx_pkg::REG_WIDTH] = tbl.rd_addr_lo;
    pcie_readdata_0[queue_ctx_pkg::SLOT_ADDR_HI*queue_ctx_pkg::REG_WIDTH +:
        queue_ctx_pkg::REG_WIDTH] = tbl.rd_addr_hi;
end

assign pcie_readdatavalid_0 = rd_flight[READ_LATENCY-1];

endmodule

// File: bram_wait_timer.sv
`timescale 1ns/1ps

module bram_wait_timer #(
    parameter int READ_LATENCY = 2
) (
    input  logic pcie_clk,
    input  logic pcie_reset_n,
    input  logic start,
    output logic done
);

localparam int COUNT_WIDTH = $clog2(READ_LATENCY + 1);

logic [COUNT_WIDTH-1:0] count;

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        count <= '0;
    end else if (start) begin
        count <= COUNT_WIDTH'(READ_LATENCY);
    end else if (count != '0) begin
        count <= count - 1'b1;
    end
end

// high in the last waiting cycle, the count steps to zero at its end
assign done = (count == COUNT_WIDTH'(1));

endmodule

// File: queue_switch_fsm.sv
`timescale 1ns/1ps

module queue_switch_fsm (
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,
    input  logic                       dma_start,
    input  queue_ctx_pkg::queue_idx_t  dma_queue,
    input  logic                       dma_done,
    input  queue_ctx_pkg::ring_ptr_t   new_tail,
    output logic                       queue_ready,
    output queue_ctx_pkg::queue_idx_t  active_queue,
    output queue_ctx_pkg::ring_ptr_t   active_tail,
    output queue_ctx_pkg::ring_ptr_t   active_head,
    output queue_ctx_pkg::kmem_addr_t  active_kmem_addr,
    queue_table_if.user                tbl,
    host_write_if.sink                 host_wr,
    output logic                       timer_start,
    input  logic                       timer_done
);

queue_ctx_pkg::switch_state_t state;
queue_ctx_pkg::queue_idx_t    next_queue;
logic                         host_hit;

assign host_hit = (host_wr.page == active_queue);

// the timer starts together with the table read of the new queue
assign timer_start = (state == queue_ctx_pkg::IDLE) && dma_start &&
    (dma_queue != active_queue);

// port a only writes back tails
assign tbl.wr_head = '0;
assign tbl.wr_addr_lo = '0;
assign tbl.wr_addr_hi = '0;

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        state <= queue_ctx_pkg::IDLE;
        queue_ready <= 1'b0;
        active_queue <= '0;
        active_tail <= '0;
        active_head <= '0;
        active_kmem_addr <= '0;
        tbl.rd_en <= 1'b0;
        tbl.wr_en <= '0;
    end else begin
        tbl.rd_en <= 1'b0;
        tbl.wr_en <= '0;

        // host updates to the active page go straight into the live context
        if (host_hit) begin
            if (host_wr.strobe[queue_ctx_pkg::SLOT_TAIL]) begin
                active_tail <= host_wr.word[queue_ctx_pkg::SLOT_TAIL];
            end
            if (host_wr.strobe[queue_ctx_pkg::SLOT_HEAD]) begin
                active_head <= host_wr.word[queue_ctx_pkg::SLOT_HEAD];
            end
            if (host_wr.strobe[queue_ctx_pkg::SLOT_ADDR_LO]) begin
                active_kmem_addr[queue_ctx_pkg::REG_WIDTH-1:0] <=
                    host_wr.word[queue_ctx_pkg::SLOT_ADDR_LO];
            end
            if (host_wr.strobe[queue_ctx_pkg::SLOT_ADDR_HI]) begin
                active_kmem_addr[2*queue_ctx_pkg::REG_WIDTH-1:queue_ctx_pkg::REG_WIDTH] <=
                    host_wr.word[queue_ctx_pkg::SLOT_ADDR_HI];
            end
        end

        case (state)
            queue_ctx_pkg::IDLE: begin
                if (dma_start) begin
                    if (dma_queue != active_queue) begin
                        tbl.addr <= dma_queue;
                        tbl.rd_en <= 1'b1;
                        next_queue <= dma_queue;
                        state <= queue_ctx_pkg::WAIT_TABLE;
                    end else begin
                        queue_ready <= 1'b1;
                        state <= queue_ctx_pkg::WAIT_DMA;
                    end
                end
            end
            queue_ctx_pkg::WAIT_TABLE: begin
                if (timer_done) begin
                    state <= queue_ctx_pkg::SWITCH_QUEUE;
                end
            end
            queue_ctx_pkg::SWITCH_QUEUE: begin
                active_tail <= tbl.rd_tail;
                active_head <= tbl.rd_head;
                active_kmem_addr <= {tbl.rd_addr_hi, tbl.rd_addr_lo};
                active_queue <= next_queue;
                queue_ready <= 1'b1;
                state <= queue_ctx_pkg::WAIT_DMA;
            end
            queue_ctx_pkg::WAIT_DMA: begin
                // overrides a host tail write in the same cycle
                if (dma_done) begin
                    active_tail <= new_tail;
                    tbl.addr <= active_queue;
                    tbl.wr_tail <= new_tail;
                    tbl.wr_en[queue_ctx_pkg::SLOT_TAIL] <= 1'b1;
                    queue_ready <= 1'b0;
                    state <= queue_ctx_pkg::IDLE;
                end
            end
            default: state <= queue_ctx_pkg::IDLE;
        endcase
    end
end

endmodule

// File: queue_ctx_top.sv
`timescale 1ns/1ps

module queue_ctx_top #(
    parameter int QUEUE_COUNT  = 16,
    parameter int READ_LATENCY = 2
) (
    input  logic                                      pcie_clk,
    input  logic                                      pcie_reset_n,

    // host register window
    input  logic [queue_ctx_pkg::PCIE_ADDR_WIDTH-1:0] pcie_address_0,
    input  logic                                      pcie_write_0,
    input  logic                                      pcie_read_0,
    input  queue_ctx_pkg::host_line_t                 pcie_writedata_0,
    input  queue_ctx_pkg::byte_mask_t                 pcie_byteenable_0,
    output queue_ctx_pkg::host_line_t                 pcie_readdata_0,
    output logic                                      pcie_readdatavalid_0,

    // dma engine side
    input  logic                                      dma_start,
    input  queue_ctx_pkg::queue_idx_t                 dma_queue,
    input  logic                                      dma_done,
    input  queue_ctx_pkg::ring_ptr_t                  new_tail,
    output logic                                      queue_ready,
    output queue_ctx_pkg::queue_idx_t                 active_queue,
    output queue_ctx_pkg::ring_ptr_t                  active_tail,
    output queue_ctx_pkg::ring_ptr_t                  active_head,
    output queue_ctx_pkg::kmem_addr_t                 active_kmem_addr
);

if (QUEUE_COUNT > (1 << queue_ctx_pkg::QUEUE_IDX_WIDTH)) begin : g_depth_check
    $error("QUEUE_COUNT does not fit the queue index width");
end

if (READ_LATENCY < 2) begin : g_latency_check
    $error("READ_LATENCY must be at least 2");
end

logic timer_start;
logic timer_done;

queue_table_if port_a ();
queue_table_if port_b ();
host_write_if  host_wr ();

queue_table #(
    .QUEUE_COUNT  (QUEUE_COUNT),
    .READ_LATENCY (READ_LATENCY)
) queue_table_inst (
    .pcie_clk (pcie_clk),
    .port_a   (port_a.tbl),
    .port_b   (port_b.tbl)
);

host_reg_port #(
    .READ_LATENCY (READ_LATENCY)
) host_reg_port_inst (
    .pcie_clk             (pcie_clk),
    .pcie_reset_n         (pcie_reset_n),
    .pcie_address_0       (pcie_address_0),
    .pcie_write_0         (pcie_write_0),
    .pcie_read_0          (pcie_read_0),
    .pcie_writedata_0     (pcie_writedata_0),
    .pcie_byteenable_0    (pcie_byteenable_0),
    .pcie_readdata_0      (pcie_readdata_0),
    .pcie_readdatavalid_0 (pcie_readdatavalid_0),
    .tbl                  (port_b.user),
    .host_wr              (host_wr.source)
);

bram_wait_timer #(
    .READ_LATENCY (READ_LATENCY)
) bram_wait_timer_inst (
    .pcie_clk     (pcie_clk),
    .pcie_reset_n (pcie_reset_n),
    .start        (timer_start),
    .done         (timer_done)
);

queue_switch_fsm queue_switch_fsm_inst (
    .pcie_clk         (pcie_clk),
    .pcie_reset_n     (pcie_reset_n),
    .dma_start        (dma_start),
    .dma_queue        (dma_queue),
    .dma_done         (dma_done),
    .new_tail         (new_tail),
    .queue_ready      (queue_ready),
    .active_queue     (active_queue),
    .active_tail      (active_tail),
    .active_head      (active_head),
    .active_kmem_addr (active_kmem_addr),
    .tbl              (port_a.user),
    .host_wr          (host_wr.sink),
    .timer_start      (timer_start),
    .timer_done       (timer_done)
);

endmodule

// File: queue_ctx_chk.sv
`timescale 1ns/1ps

module queue_ctx_chk (
    input logic                      pcie_clk,
    input logic                      pcie_reset_n,
    input logic                      pcie_readdatavalid_0,
    input logic                      queue_ready,
    input logic                      dma_done,
    input queue_ctx_pkg::queue_idx_t active_queue
);

int assert_failures = 0;

// one read in flight at most
valid_single_pulse: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
    pcie_readdatavalid_0 |=> !pcie_readdatavalid_0)
    else begin
        $error("pcie_readdatavalid_0 stayed high for two cycles");
        assert_failures++;
    end

// ready holds until dma_done has been seen
ready_holds: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
    queue_ready && !dma_done |=> queue_ready)
    else begin
        $error("queue_ready fell without dma_done");
        assert_failures++;
    end

ready_drops: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
    queue_ready && dma_done |=> !queue_ready)
    else begin
        $error("queue_ready still high after dma_done");
        assert_failures++;
    end

queue_stable: assert property (@(posedge pcie_clk) disable iff (!pcie_reset_n)
    queue_ready |=> $stable(active_queue))
    else begin
        $error("active_queue changed while queue_ready was high");
        assert_failures++;
    end

endmodule

bind queue_ctx_top queue_ctx_chk queue_ctx_chk_inst (
    .pcie_clk             (pcie_clk),
    .pcie_reset_n         (pcie_reset_n),
    .pcie_readdatavalid_0 (pcie_readdatavalid_0),
    .queue_ready          (queue_ready),
    .dma_done             (dma_done),
    .active_queue         (active_queue)
);

// File: tb_queue_ctx.sv
`timescale 1ns/1ps

module tb_queue_ctx;

localparam int QUEUE_COUNT = 16;
localparam int WAIT_LIMIT = 20;
localparam int READ_CYCLES = 3;
localparam int SWITCH_CYCLES = 4;
localparam int REUSE_CYCLES = 1;

logic                                      pcie_clk = 1'b0;
logic                                      pcie_reset_n;
logic [queue_ctx_pkg::PCIE_ADDR_WIDTH-1:0] pcie_address_0;
logic                                      pcie_write_0;
logic                                      pcie_read_0;
queue_ctx_pkg::host_line_t                 pcie_writedata_0;
queue_ctx_pkg::byte_mask_t                 pcie_byteenable_0;
queue_ctx_pkg::host_line_t                 pcie_readdata_0;
logic                                      pcie_readdatavalid_0;
logic                                      dma_start;
queue_ctx_pkg::queue_idx_t                 dma_queue;
logic                                      dma_done;
queue_ctx_pkg::ring_ptr_t                  new_tail;
logic                                      queue_ready;
queue_ctx_pkg::queue_idx_t                 active_queue;
queue_ctx_pkg::ring_ptr_t                  active_tail;
queue_ctx_pkg::ring_ptr_t                  active_head;
queue_ctx_pkg::kmem_addr_t                 active_kmem_addr;

int check_count = 0;
int error_count = 0;
int timeout_count = 0;
int assert_failures = 0;

// expected table contents and live context
queue_ctx_pkg::reg_word_t  exp_tail [QUEUE_COUNT];
logic                      tail_known [QUEUE_COUNT];
queue_ctx_pkg::reg_word_t  exp_head [QUEUE_COUNT];
queue_ctx_pkg::reg_word_t  exp_addr_lo [QUEUE_COUNT];
queue_ctx_pkg::reg_word_t  exp_addr_hi [QUEUE_COUNT];
queue_ctx_pkg::queue_idx_t exp_queue;
queue_ctx_pkg::ring_ptr_t  exp_active_tail;
logic                      exp_active_tail_known;
queue_ctx_pkg::ring_ptr_t  exp_active_head;
queue_ctx_pkg::kmem_addr_t exp_active_kmem;

always #50 pcie_clk = ~pcie_clk;

queue_ctx_top queue_ctx_top_inst (
    .pcie_clk             (pcie_clk),
    .pcie_reset_n         (pcie_reset_n),
    .pcie_address_0       (pcie_address_0),
    .pcie_write_0         (pcie_write_0),
    .pcie_read_0          (pcie_read_0),
    .pcie_writedata_0     (pcie_writedata_0),
    .pcie_byteenable_0    (pcie_byteenable_0),
    .pcie_readdata_0      (pcie_readdata_0),
    .pcie_readdatavalid_0 (pcie_readdatavalid_0),
    .dma_start            (dma_start),
    .dma_queue            (dma_queue),
    .dma_done             (dma_done),
    .new_tail             (new_tail),
    .queue_ready          (queue_ready),
    .active_queue         (active_queue),
    .active_tail          (active_tail),
    .active_head          (active_head),
    .active_kmem_addr     (active_kmem_addr)
);

task automatic check_value(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
    check_count++;
    if (actual !== expected) begin
        error_count++;
        $display("ERROR: %s is 0x%0h, expected 0x%0h", name, actual, expected);
    end
endtask

task automatic report_timeout(input string what);
    timeout_count++;
    $display("timeout: %s did not arrive within %0d cycles", what, WAIT_LIMIT);
endtask

task automatic check_context();
    check_value("active_queue", active_queue, exp_queue);
    if (exp_active_tail_known) begin
        check_value("active_tail", active_tail, exp_active_tail);
    end
    check_value("active_head", active_head, exp_active_head);
    check_value("active_kmem_addr", active_kmem_addr, exp_active_kmem);
endtask

// random words in slots 0 to 3, a slot counts only with all four bytes enabled
task automatic host_write(input queue_ctx_pkg::queue_idx_t page, input logic [15:0] byte_en);
    queue_ctx_pkg::host_line_t line;
    queue_ctx_pkg::reg_word_t  word [4];
    logic                      hit;
    line = '0;
    hit = (page == exp_queue);
    for (int s = 0; s < 4; s++) begin
        word[s] = $urandom();
        line[s*32 +: 32] = word[s];
    end
    @(posedge pcie_clk);
    pcie_address_0 <= 64'(page) << queue_ctx_pkg::PAGE_LSB;
    pcie_writedata_0 <= line;
    pcie_byteenable_0 <= {48'h0, byte_en};
    pcie_write_0 <= 1'b1;
    @(posedge pcie_clk);
    pcie_write_0 <= 1'b0;
    pcie_byteenable_0 <= '0;
    if (&byte_en[3:0] && hit) begin
        // tail goes to the live context only, never to the table
        exp_active_tail = word[queue_ctx_pkg::SLOT_TAIL];
        exp_active_tail_known = 1'b1;
    end
    if (&byte_en[7:4]) begin
        exp_head[page] = word[queue_ctx_pkg::SLOT_HEAD];
        if (hit) exp_active_head = word[queue_ctx_pkg::SLOT_HEAD];
    end
    if (&byte_en[11:8]) begin
        exp_addr_lo[page] = word[queue_ctx_pkg::SLOT_ADDR_LO];
        if (hit) exp_active_kmem[31:0] = word[queue_ctx_pkg::SLOT_ADDR_LO];
    end
    if (&byte_en[15:12]) begin
        exp_addr_hi[page] = word[queue_ctx_pkg::SLOT_ADDR_HI];
        if (hit) exp_active_kmem[63:32] = word[queue_ctx_pkg::SLOT_ADDR_HI];
    end
endtask

task automatic read_page_check(input queue_ctx_pkg::queue_idx_t page);
    queue_ctx_pkg::host_line_t line;
    int                        cycles;
    logic                      found;
    @(posedge pcie_clk);
    pcie_address_0 <= 64'(page) << queue_ctx_pkg::PAGE_LSB;
    pcie_read_0 <= 1'b1;
    @(posedge pcie_clk);
    pcie_read_0 <= 1'b0;
    cycles = 1;
    found = 1'b0;
    line = '0;
    while (!found && cycles <= WAIT_LIMIT) begin
        @(negedge pcie_clk);
        if (pcie_readdatavalid_0) begin
            found = 1'b1;
            line = pcie_readdata_0;
        end else begin
            @(posedge pcie_clk);
            cycles++;
        end
    end
    if (!found) begin
        report_timeout("pcie_readdatavalid_0");
    end else begin
        check_value("pcie_readdatavalid_0 latency", cycles, READ_CYCLES);
        if (tail_known[page]) begin
            check_value("pcie_readdata_0 word 0", line[31:0], exp_tail[page]);
        end
        check_value("pcie_readdata_0 word 1", line[63:32], exp_head[page]);
        check_value("pcie_readdata_0 word 2", line[95:64], exp_addr_lo[page]);
        check_value("pcie_readdata_0 word 3", line[127:96], exp_addr_hi[page]);
        for (int w = 4; w < 16; w++) begin
            check_value($sformatf("pcie_readdata_0 word %0d", w), line[w*32 +: 32], 64'h0);
        end
    end
endtask

task automatic start_dma(input queue_ctx_pkg::queue_idx_t queue, input int expect_cycles);
    int   cycles;
    logic found;
    @(posedge pcie_clk);
    dma_queue <= queue;
    dma_start <= 1'b1;
    @(posedge pcie_clk);
    dma_start <= 1'b0;
    if (queue != exp_queue) begin
        exp_queue = queue;
        exp_active_tail = exp_tail[queue];
        exp_active_tail_known = tail_known[queue];
        exp_active_head = exp_head[queue];
        exp_active_kmem = {exp_addr_hi[queue], exp_addr_lo[queue]};
    end
    cycles = 1;
    found = 1'b0;
    while (!found && cycles <= WAIT_LIMIT) begin
        @(negedge pcie_clk);
        if (queue_ready) begin
            found = 1'b1;
        end else begin
            @(posedge pcie_clk);
            cycles++;
        end
    end
    if (!found) begin
        report_timeout("queue_ready");
    end else begin
        check_value("queue_ready latency", cycles, expect_cycles);
        check_context();
    end
endtask

task automatic finish_dma(input queue_ctx_pkg::ring_ptr_t tail);
    @(posedge pcie_clk);
    new_tail <= tail;
    dma_done <= 1'b1;
    @(posedge pcie_clk);
    dma_done <= 1'b0;
    exp_tail[exp_queue] = tail;
    tail_known[exp_queue] = 1'b1;
    exp_active_tail = tail;
    exp_active_tail_known = 1'b1;
    @(negedge pcie_clk);
    check_value("queue_ready", queue_ready, 64'h0);
    check_context();
endtask

task automatic test_reset_state();
    @(negedge pcie_clk);
    check_value("queue_ready", queue_ready, 64'h0);
    check_value("pcie_readdatavalid_0", pcie_readdatavalid_0, 64'h0);
    check_context();
endtask

task automatic test_write_read();
    host_write(4'd3, 16'hFFFF);
    host_write(4'd9, 16'hFFFF);
    read_page_check(4'd3);
    read_page_check(4'd9);
endtask

task automatic test_partial_enable();
    // head slot of page 3 and low address slot of page 9 are only partly enabled
    host_write(4'd3, 16'hFF7F);
    read_page_check(4'd3);
    host_write(4'd9, 16'hF7FF);
    read_page_check(4'd9);
endtask

task automatic test_queue_switch();
    start_dma(4'd9, SWITCH_CYCLES);
    finish_dma($urandom());
    start_dma(4'd9, REUSE_CYCLES);
    finish_dma($urandom());
endtask

task automatic test_dma_done();
    start_dma(4'd9, REUSE_CYCLES);
    finish_dma($urandom());
    read_page_check(4'd9);
endtask

task automatic test_active_page_write();
    queue_ctx_pkg::ring_ptr_t  old_tail;
    queue_ctx_pkg::ring_ptr_t  old_head;
    queue_ctx_pkg::kmem_addr_t old_kmem;
    old_tail = exp_active_tail;
    old_head = exp_active_head;
    old_kmem = exp_active_kmem;
    host_write(4'd9, 16'hFFFF);
    @(negedge pcie_clk);
    check_value("active_tail", active_tail, old_tail);
    check_value("active_head", active_head, old_head);
    check_value("active_kmem_addr", active_kmem_addr, old_kmem);
    @(negedge pcie_clk);
    check_context();
    // another page must not touch the live context
    host_write(4'd3, 16'hFFFF);
    @(negedge pcie_clk);
    @(negedge pcie_clk);
    check_context();
    read_page_check(4'd9);
endtask

initial begin
    void'($urandom(41716));
    pcie_reset_n = 1'b0;
    pcie_address_0 = '0;
    pcie_write_0 = 1'b0;
    pcie_read_0 = 1'b0;
    pcie_writedata_0 = '0;
    pcie_byteenable_0 = '0;
    dma_start = 1'b0;
    dma_queue = '0;
    dma_done = 1'b0;
    new_tail = '0;
    for (int q = 0; q < QUEUE_COUNT; q++) begin
        tail_known[q] = 1'b0;
        exp_tail[q] = '0;
    end
    exp_queue = '0;
    exp_active_tail = '0;
    exp_active_tail_known = 1'b1;
    exp_active_head = '0;
    exp_active_kmem = '0;

    repeat (5) @(posedge pcie_clk);
    pcie_reset_n <= 1'b1;

    test_reset_state();
    test_write_read();
    test_partial_enable();
    test_queue_switch();
    test_dma_done();
    test_active_page_write();

    repeat (3) @(posedge pcie_clk);
    assert_failures = queue_ctx_top_inst.queue_ctx_chk_inst.assert_failures;
    $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
        check_count, error_count, timeout_count, assert_failures);
    if (error_count == 0 && timeout_count == 0 && assert_failures == 0) begin
        $display("All checks passed");
    end else begin
        $display("Checks failed");
    end
    $finish;
end

endmodule

// File: project.f
queue_ctx_pkg.sv
queue_table_if.sv
queue_table.sv
host_reg_port.sv
bram_wait_timer.sv
queue_switch_fsm.sv
queue_ctx_top.sv
queue_ctx_chk.sv
tb_queue_ctx.sv

// File: Makefile
VERILATOR  := verilator
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing
TOP        := tb_queue_ctx
RTL_TOP    := queue_ctx_top
FILELIST   := project.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := All checks passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	rm -f $(LOG)
	./$(BUILD_DIR)/V$(TOP) +verilator+error+limit+100 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
